//--- common/blob_pkg.sv
package blob_pkg;

    // frame geometry
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 12;

    // a pixel is bright when its luma is at or above this level
    localparam int GRAY_THRESH = 128;

    // field widths
    localparam int RGB_W = 24;
    localparam int GRAY_W = 8;
    localparam int X_W = 4;
    localparam int Y_W = 4;
    localparam int CNT_W = 8;

    // luma weights, their sum is 256 so the result is scaled back by 8 bits
    localparam int LUMA_R = 77;
    localparam int LUMA_G = 150;
    localparam int LUMA_B = 29;
    localparam int LUMA_SHIFT = 8;
    localparam int LUMA_SUM_W = GRAY_W + LUMA_SHIFT;

    // red sits in the top byte, blue in the bottom byte
    typedef logic [RGB_W-1:0] rgb_t;

    typedef logic [GRAY_W-1:0] gray_t;

    typedef logic [X_W-1:0] coord_x_t;

    typedef logic [Y_W-1:0] coord_y_t;

    typedef logic [CNT_W-1:0] count_t;

endpackage

//--- hdl/frame_sync_ctrl.sv
module frame_sync_ctrl (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_proc_active,
    input  logic i_vga_vsync,
    input  logic i_blob_done,
    output logic o_grayscale_start,
    output logic o_blob_end
);

    typedef enum logic [1:0] {
        ST_WAIT_ACT,
        ST_WAIT_VS_ON,
        ST_WAIT_INACT,
        ST_WAIT_VS_OFF
    } start_state_t;

    typedef enum logic [1:0] {
        EN_WAIT_DONE,
        EN_WAIT_VS,
        EN_IDLE
    } end_state_t;

    start_state_t start_state_q;
    start_state_t start_state_d;
    logic         start_q;
    logic         start_d;

    end_state_t end_state_q;
    end_state_t end_state_d;
    logic       end_q;
    logic       end_d;

    assign o_grayscale_start = start_q;
    assign o_blob_end = end_q;

    // start level only changes on a vsync boundary
    always_comb begin
        start_state_d = start_state_q;
        start_d = start_q;
        case (start_state_q)
            ST_WAIT_ACT: begin
                if (i_proc_active && i_vga_vsync) begin
                    start_state_d = ST_WAIT_INACT;
                    start_d = 1'b1;
                end else if (i_proc_active) begin
                    start_state_d = ST_WAIT_VS_ON;
                end
            end
            ST_WAIT_VS_ON: begin
                if (i_vga_vsync) begin
                    start_state_d = ST_WAIT_INACT;
                    start_d = 1'b1;
                end
            end
            ST_WAIT_INACT: begin
                if (!i_proc_active && i_vga_vsync) begin
                    start_state_d = ST_WAIT_ACT;
                    start_d = 1'b0;
                end else if (!i_proc_active) begin
                    start_state_d = ST_WAIT_VS_OFF;
                end
            end
            ST_WAIT_VS_OFF: begin
                if (i_vga_vsync) begin
                    start_state_d = ST_WAIT_ACT;
                    start_d = 1'b0;
                end
            end
            default: begin
                start_state_d = ST_WAIT_ACT;
                start_d = 1'b0;
            end
        endcase
    end

    // blob end is a single pulse, then rearm once the front end goes idle
    always_comb begin
        end_state_d = end_state_q;
        end_d = 1'b0;
        case (end_state_q)
            EN_WAIT_DONE: begin
                if (i_blob_done && i_vga_vsync) begin
                    end_state_d = EN_IDLE;
                    end_d = 1'b1;
                end else if (i_blob_done) begin
                    end_state_d = EN_WAIT_VS;
                end
            end
            EN_WAIT_VS: begin
                if (i_vga_vsync) begin
                    end_state_d = EN_IDLE;
                    end_d = 1'b1;
                end
            end
            EN_IDLE: begin
                if (!i_proc_active) begin
                    end_state_d = EN_WAIT_DONE;
                end
            end
            default: begin
                end_state_d = EN_WAIT_DONE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_state_q <= ST_WAIT_ACT;
            start_q <= 1'b0;
            end_state_q <= EN_WAIT_DONE;
            end_q <= 1'b0;
        end else begin
            start_state_q <= start_state_d;
            start_q <= start_d;
            end_state_q <= end_state_d;
            end_q <= end_d;
        end
    end

endmodule

//--- blob/gray_convert.sv
module gray_convert (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_valid,
    input  blob_pkg::rgb_t i_rgb,
    input  logic           i_last,
    output logic           o_ready,
    output logic           o_valid,
    output blob_pkg::gray_t o_gray,
    output logic           o_last,
    input  logic           i_ready
);

    import blob_pkg::*;

    logic [GRAY_W-1:0]     red;
    logic [GRAY_W-1:0]     green;
    logic [GRAY_W-1:0]     blue;
    logic [LUMA_SUM_W-1:0] luma_sum;
    logic                  accept;

    logic  valid_q;
    gray_t gray_q;
    logic  last_q;

    assign red = i_rgb[RGB_W-1 -: GRAY_W];
    assign green = i_rgb[RGB_W-GRAY_W-1 -: GRAY_W];
    assign blue = i_rgb[GRAY_W-1:0];

    // weights add up to 256, so the sum never overflows
    assign luma_sum = LUMA_SUM_W'(LUMA_R) * LUMA_SUM_W'(red)
                    + LUMA_SUM_W'(LUMA_G) * LUMA_SUM_W'(green)
                    + LUMA_SUM_W'(LUMA_B) * LUMA_SUM_W'(blue);

    // stage may refill in the cycle it drains
    assign o_ready = !valid_q || i_ready;
    assign accept = i_valid && o_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            gray_q <= luma_sum[LUMA_SUM_W-1 -: GRAY_W];
            last_q <= i_last;
        end
    end

    assign o_valid = valid_q;
    assign o_gray = gray_q;
    assign o_last = last_q;

endmodule

//--- blob/blob_tracker.sv
module blob_tracker (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  blob_pkg::gray_t    i_gray,
    input  logic               i_last,
    output logic               o_ready,
    output logic               o_blob_done,
    output logic               o_found,
    output blob_pkg::coord_x_t o_min_x,
    output blob_pkg::coord_x_t o_max_x,
    output blob_pkg::coord_y_t o_min_y,
    output blob_pkg::coord_y_t o_max_y,
    output blob_pkg::count_t   o_count
);

    import blob_pkg::*;

    logic     accept;
    logic     bright;
    logic     fresh_q;
    coord_x_t x_q;
    coord_y_t y_q;

    logic     found_q;
    count_t   count_q;
    coord_x_t min_x_q;
    coord_x_t max_x_q;
    coord_y_t min_y_q;
    coord_y_t max_y_q;

    logic     base_found;
    count_t   base_count;
    coord_x_t base_min_x;
    coord_x_t base_max_x;
    coord_y_t base_min_y;
    coord_y_t base_max_y;

    logic     found_d;
    count_t   count_d;
    coord_x_t min_x_d;
    coord_x_t max_x_d;
    coord_y_t min_y_d;
    coord_y_t max_y_d;

    assign o_ready = 1'b1;
    assign accept = i_valid && o_ready;
    assign bright = i_gray >= gray_t'(GRAY_THRESH);
    assign o_blob_done = accept && i_last;

    always_comb begin
        // first pixel of a frame starts from an empty box
        base_found = fresh_q ? 1'b0 : found_q;
        base_count = fresh_q ? '0 : count_q;
        base_min_x = fresh_q ? '0 : min_x_q;
        base_max_x = fresh_q ? '0 : max_x_q;
        base_min_y = fresh_q ? '0 : min_y_q;
        base_max_y = fresh_q ? '0 : max_y_q;
        found_d = base_found;
        count_d = base_count;
        min_x_d = base_min_x;
        max_x_d = base_max_x;
        min_y_d = base_min_y;
        max_y_d = base_max_y;
        if (bright) begin
            found_d = 1'b1;
            count_d = base_count + count_t'(1);
            if (!base_found || x_q < base_min_x) min_x_d = x_q;
            if (!base_found || x_q > base_max_x) max_x_d = x_q;
            if (!base_found || y_q < base_min_y) min_y_d = y_q;
            if (!base_found || y_q > base_max_y) max_y_d = y_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_q <= '0;
            y_q <= '0;
            fresh_q <= 1'b1;
            found_q <= 1'b0;
            count_q <= '0;
        end else if (accept) begin
            found_q <= found_d;
            count_q <= count_d;
            fresh_q <= i_last;
            if (i_last) begin
                x_q <= '0;
                y_q <= '0;
            end else if (x_q == coord_x_t'(FRAME_W - 1)) begin
                x_q <= '0;
                y_q <= (y_q == coord_y_t'(FRAME_H - 1)) ? '0 : y_q + coord_y_t'(1);
            end else begin
                x_q <= x_q + coord_x_t'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            min_x_q <= min_x_d;
            max_x_q <= max_x_d;
            min_y_q <= min_y_d;
            max_y_q <= max_y_d;
        end
    end

    assign o_found = found_q;
    assign o_count = count_q;
    assign o_min_x = min_x_q;
    assign o_max_x = max_x_q;
    assign o_min_y = min_y_q;
    assign o_max_y = max_y_q;

endmodule

//--- blob/blob_report.sv
module blob_report (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_blob_end,
    input  logic               i_found,
    input  blob_pkg::coord_x_t i_min_x,
    input  blob_pkg::coord_x_t i_max_x,
    input  blob_pkg::coord_y_t i_min_y,
    input  blob_pkg::coord_y_t i_max_y,
    input  blob_pkg::count_t   i_count,
    output logic               o_res_valid,
    output logic               o_res_found,
    output blob_pkg::coord_x_t o_res_min_x,
    output blob_pkg::coord_x_t o_res_max_x,
    output blob_pkg::coord_y_t o_res_min_y,
    output blob_pkg::coord_y_t o_res_max_y,
    output blob_pkg::count_t   o_res_count,
    input  logic               i_res_ready
);

    import blob_pkg::*;

    logic     capture;
    logic     valid_q;
    logic     found_q;
    coord_x_t min_x_q;
    coord_x_t max_x_q;
    coord_y_t min_y_q;
    coord_y_t max_y_q;
    count_t   count_q;

    // a new frame end is dropped while the previous result still waits
    assign capture = i_blob_end && !valid_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= 1'b1;
        end else if (valid_q && i_res_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) begin
            found_q <= i_found;
            min_x_q <= i_min_x;
            max_x_q <= i_max_x;
            min_y_q <= i_min_y;
            max_y_q <= i_max_y;
            count_q <= i_count;
        end
    end

    assign o_res_valid = valid_q;
    assign o_res_found = found_q;
    assign o_res_min_x = min_x_q;
    assign o_res_max_x = max_x_q;
    assign o_res_min_y = min_y_q;
    assign o_res_max_y = max_y_q;
    assign o_res_count = count_q;

endmodule

//--- hdl/blob_top.sv
module blob_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_proc_active,
    input  logic               i_vga_vsync,
    input  logic               i_pix_valid,
    input  blob_pkg::rgb_t     i_pix_rgb,
    input  logic               i_pix_last,
    output logic               o_pix_ready,
    output logic               o_res_valid,
    output logic               o_res_found,
    output blob_pkg::coord_x_t o_res_min_x,
    output blob_pkg::coord_x_t o_res_max_x,
    output blob_pkg::coord_y_t o_res_min_y,
    output blob_pkg::coord_y_t o_res_max_y,
    output blob_pkg::count_t   o_res_count,
    input  logic               i_res_ready
);

    import blob_pkg::*;

    logic     grayscale_start;
    logic     blob_end;
    logic     blob_done;
    logic     pix_valid_gated;
    logic     gray_ready;
    logic     gray_valid;
    gray_t    gray_luma;
    logic     gray_last;
    logic     trk_ready;
    logic     trk_found;
    coord_x_t trk_min_x;
    coord_x_t trk_max_x;
    coord_y_t trk_min_y;
    coord_y_t trk_max_y;
    count_t   trk_count;

    // pixels only enter between the two vsync boundaries of a frame
    assign o_pix_ready = grayscale_start & gray_ready;
    assign pix_valid_gated = i_pix_valid & grayscale_start;

    frame_sync_ctrl u_sync (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_proc_active    (i_proc_active),
        .i_vga_vsync      (i_vga_vsync),
        .i_blob_done      (blob_done),
        .o_grayscale_start(grayscale_start),
        .o_blob_end       (blob_end)
    );

    gray_convert u_gray (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_valid(pix_valid_gated),
        .i_rgb  (i_pix_rgb),
        .i_last (i_pix_last),
        .o_ready(gray_ready),
        .o_valid(gray_valid),
        .o_gray (gray_luma),
        .o_last (gray_last),
        .i_ready(trk_ready)
    );

    blob_tracker u_tracker (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (gray_valid),
        .i_gray     (gray_luma),
        .i_last     (gray_last),
        .o_ready    (trk_ready),
        .o_blob_done(blob_done),
        .o_found    (trk_found),
        .o_min_x    (trk_min_x),
        .o_max_x    (trk_max_x),
        .o_min_y    (trk_min_y),
        .o_max_y    (trk_max_y),
        .o_count    (trk_count)
    );

    blob_report u_report (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_blob_end (blob_end),
        .i_found    (trk_found),
        .i_min_x    (trk_min_x),
        .i_max_x    (trk_max_x),
        .i_min_y    (trk_min_y),
        .i_max_y    (trk_max_y),
        .i_count    (trk_count),
        .o_res_valid(o_res_valid),
        .o_res_found(o_res_found),
        .o_res_min_x(o_res_min_x),
        .o_res_max_x(o_res_max_x),
        .o_res_min_y(o_res_min_y),
        .o_res_max_y(o_res_max_y),
        .o_res_count(o_res_count),
        .i_res_ready(i_res_ready)
    );

endmodule

//--- verif/tb_clk_gen.sv
module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 10;

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // release away from the rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

//--- verif/blob_chk.sv
module blob_chk (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_res_valid,
    input logic i_res_ready,
    input logic [2*blob_pkg::X_W + 2*blob_pkg::Y_W + blob_pkg::CNT_W:0] i_res_fields,
    input logic i_blob_end,
    input logic i_grayscale_start,
    input logic i_gray_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // a waiting result holds both its valid and its payload
    property res_hold;
        @(posedge i_clk) disable iff (!i_rst_n)
        i_res_valid && !i_res_ready |=> i_res_valid && $stable(i_res_fields);
    endproperty

    a_res_hold: assert property (res_hold)
        else begin
            $error("result dropped or changed while waiting for ready");
            fail_count++;
        end

    a_end_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_blob_end |=> !i_blob_end)
        else begin
            $error("blob end stayed high for two cycles");
            fail_count++;
        end

    // the luma stage only fills from a pixel taken inside the vsync window
    a_gate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_grayscale_start |=> !i_gray_valid)
        else begin
            $error("pixel entered the luma stage while grayscale start was low");
            fail_count++;
        end

endmodule

//--- verif/blob_tb.sv
module blob_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import blob_pkg::*;

    localparam int NPIX = FRAME_W * FRAME_H;
    localparam int VS_PERIOD = 40;
    localparam int WAIT_LIMIT = 2000;
    localparam rgb_t DARK = 24'h202020;
    localparam rgb_t BRIGHT = 24'hE0F0C0;

    typedef struct packed {
        logic     found;
        coord_x_t min_x;
        coord_x_t max_x;
        coord_y_t min_y;
        coord_y_t max_y;
        count_t   count;
    } result_t;

    logic     i_clk;
    logic     i_rst_n;
    logic     i_proc_active;
    logic     i_vga_vsync;
    logic     i_pix_valid;
    rgb_t     i_pix_rgb;
    logic     i_pix_last;
    logic     o_pix_ready;
    logic     o_res_valid;
    logic     o_res_found;
    coord_x_t o_res_min_x;
    coord_x_t o_res_max_x;
    coord_y_t o_res_min_y;
    coord_y_t o_res_max_y;
    count_t   o_res_count;
    logic     i_res_ready;

    rgb_t    frame_pix [NPIX];
    result_t exp_q [$];
    int      vs_seen = 0;
    int      results_seen = 0;
    int      cmp_errors = 0;
    int      chk_errors;
    int      frames_sent;
    int      tests_run;
    int      tests_failed;

    tb_clk_gen u_clk (
        .o_clk  (i_clk),
        .o_rst_n(i_rst_n)
    );

    blob_top dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_proc_active(i_proc_active),
        .i_vga_vsync  (i_vga_vsync),
        .i_pix_valid  (i_pix_valid),
        .i_pix_rgb    (i_pix_rgb),
        .i_pix_last   (i_pix_last),
        .o_pix_ready  (o_pix_ready),
        .o_res_valid  (o_res_valid),
        .o_res_found  (o_res_found),
        .o_res_min_x  (o_res_min_x),
        .o_res_max_x  (o_res_max_x),
        .o_res_min_y  (o_res_min_y),
        .o_res_max_y  (o_res_max_y),
        .o_res_count  (o_res_count),
        .i_res_ready  (i_res_ready)
    );

    bind blob_top blob_chk u_chk (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_res_valid      (o_res_valid),
        .i_res_ready      (i_res_ready),
        .i_res_fields     ({o_res_found, o_res_min_x, o_res_max_x,
                            o_res_min_y, o_res_max_y, o_res_count}),
        .i_blob_end       (blob_end),
        .i_grayscale_start(grayscale_start),
        .i_gray_valid     (gray_valid)
    );

    // one-cycle vsync every VS_PERIOD cycles
    initial begin : vsync_gen
        int phase;
        phase = 0;
        i_vga_vsync = 1'b0;
        forever begin
            @(negedge i_clk);
            phase = (phase + 1) % VS_PERIOD;
            i_vga_vsync = (phase == VS_PERIOD - 1);
        end
    end

    always @(posedge i_clk) begin
        if (i_vga_vsync) begin
            vs_seen <= vs_seen + 1;
        end
    end

    function automatic int error_total();
        return cmp_errors + chk_errors + dut.u_chk.fail_count;
    endfunction

    function automatic string result_text(input result_t r);
        return $sformatf("found %0d x %0d..%0d y %0d..%0d count %0d",
                         r.found, r.min_x, r.max_x, r.min_y, r.max_y, r.count);
    endfunction

    // expected box and count of the stored frame
    function automatic result_t ref_result();
        result_t r;
        int      luma;
        int      x;
        int      y;
        int      min_x;
        int      max_x;
        int      min_y;
        int      max_y;
        int      count;
        logic    found;
        rgb_t    p;
        min_x = 0;
        max_x = 0;
        min_y = 0;
        max_y = 0;
        count = 0;
        found = 1'b0;
        for (int i = 0; i < NPIX; i++) begin
            p = frame_pix[i];
            luma = (LUMA_R * int'(p[23:16]) + LUMA_G * int'(p[15:8])
                    + LUMA_B * int'(p[7:0])) >> LUMA_SHIFT;
            x = i % FRAME_W;
            y = i / FRAME_W;
            if (luma >= GRAY_THRESH) begin
                if (!found || x < min_x) min_x = x;
                if (!found || x > max_x) max_x = x;
                if (!found || y < min_y) min_y = y;
                if (!found || y > max_y) max_y = y;
                found = 1'b1;
                count++;
            end
        end
        r.found = found;
        r.min_x = coord_x_t'(min_x);
        r.max_x = coord_x_t'(max_x);
        r.min_y = coord_y_t'(min_y);
        r.max_y = coord_y_t'(max_y);
        r.count = count_t'(count);
        return r;
    endfunction

    always @(posedge i_clk) begin : compare
        result_t got;
        result_t exp;
        if (i_rst_n && o_res_valid && i_res_ready) begin
            got = {o_res_found, o_res_min_x, o_res_max_x, o_res_min_y, o_res_max_y, o_res_count};
            results_seen++;
            if (exp_q.size() == 0) begin
                $display("unexpected result at %0t with no frame outstanding", $time);
                cmp_errors++;
            end else begin
                exp = exp_q.pop_front();
                assert (got == exp) else begin
                    $display("error %0t: got %s, expected %s", $time,
                             result_text(got), result_text(exp));
                    cmp_errors++;
                end
            end
        end
    end

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    // an empty range gives an all-dark frame
    task automatic fill_rect(input int x0, input int x1, input int y0, input int y1);
        int x;
        int y;
        for (int i = 0; i < NPIX; i++) begin
            x = i % FRAME_W;
            y = i / FRAME_W;
            frame_pix[i] = (x >= x0 && x <= x1 && y >= y0 && y <= y1) ? BRIGHT : DARK;
        end
    endtask

    // masked pixels stay below threshold, unmasked ones may cross it
    task automatic fill_random();
        for (int i = 0; i < NPIX; i++) begin
            frame_pix[i] = rgb_t'($urandom) & (($urandom % 6 == 0) ? 24'hFFFFFF : 24'h7F7F7F);
        end
    endtask

    task automatic send_frame(input int max_gap);
        int vs_before;
        int gap;
        int n;
        exp_q.push_back(ref_result());
        frames_sent++;
        i_proc_active = 1'b1;
        vs_before = vs_seen;
        for (int i = 0; i < NPIX; i++) begin
            gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
            repeat (gap) @(negedge i_clk);
            i_pix_valid = 1'b1;
            i_pix_rgb = frame_pix[i];
            i_pix_last = (i == NPIX - 1);
            n = 0;
            while (!o_pix_ready) begin
                @(negedge i_clk);
                n++;
                if (n > WAIT_LIMIT) abort_run("pixel ready never rose");
            end
            assert (vs_seen > vs_before) else begin
                $display("error %0t: pixel ready before the frame's first vsync", $time);
                chk_errors++;
            end
            @(negedge i_clk);
            i_pix_valid = 1'b0;
            i_pix_last = 1'b0;
        end
        i_proc_active = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        while (results_seen < target) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("frame result never arrived");
        end
    endtask

    // grayscale start falls on the vsync after the frame goes inactive
    task automatic wait_idle();
        int n;
        n = 0;
        while (o_pix_ready) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("pixel ready never fell after the frame");
        end
    endtask

    // a repeated blob end would deliver its result within this window
    task automatic wait_vsyncs(input int count);
        int target;
        int n;
        target = vs_seen + count;
        n = 0;
        while (vs_seen < target) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("vsync pulses stopped");
        end
    endtask

    task automatic run_frame(input int max_gap);
        send_frame(max_gap);
        wait_results(frames_sent);
        wait_idle();
        wait_vsyncs(2);
        assert (results_seen == frames_sent) else begin
            $display("error %0t: %0d results for %0d frames", $time, results_seen, frames_sent);
            chk_errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (error_total() != errs_before) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin : main
        int      errs;
        int      n;
        result_t snap;
        void'($urandom(32'h397c7e50));
        i_proc_active = 1'b0;
        i_pix_valid = 1'b0;
        i_pix_rgb = '0;
        i_pix_last = 1'b0;
        i_res_ready = 1'b1;
        chk_errors = 0;
        frames_sent = 0;
        tests_run = 0;
        tests_failed = 0;
        n = 0;
        while (i_rst_n !== 1'b1) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("reset never released");
        end
        repeat (3) @(negedge i_clk);

        errs = error_total();
        fill_rect(5, 5, 3, 3);
        run_frame(0);
        end_test("start waits for vsync", errs);

        errs = error_total();
        fill_rect(3, 9, 2, 6);
        run_frame(0);
        end_test("bright rectangle", errs);

        errs = error_total();
        fill_rect(1, 0, 1, 0);
        run_frame(0);
        end_test("all dark frame", errs);

        errs = error_total();
        fill_random();
        run_frame(3);
        end_test("random frame with gaps", errs);

        errs = error_total();
        i_res_ready = 1'b0;
        fill_rect(2, 13, 4, 10);
        send_frame(1);
        n = 0;
        while (!o_res_valid) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("result valid never rose");
        end
        snap = {o_res_found, o_res_min_x, o_res_max_x, o_res_min_y, o_res_max_y, o_res_count};
        repeat (12) begin
            @(negedge i_clk);
            assert (o_res_valid && snap == {o_res_found, o_res_min_x, o_res_max_x,
                                             o_res_min_y, o_res_max_y, o_res_count})
            else begin
                $display("error %0t: held result changed", $time);
                chk_errors++;
            end
        end
        i_res_ready = 1'b1;
        wait_results(frames_sent);
        wait_vsyncs(2);
        assert (results_seen == frames_sent && !o_res_valid) else begin
            $display("error %0t: extra result after the held one", $time);
            chk_errors++;
        end
        wait_idle();
        end_test("result held under back-pressure", errs);

        errs = error_total();
        fill_rect(1, 12, 1, 9);
        run_frame(2);
        fill_rect(10, 13, 7, 10);
        run_frame(2);
        end_test("two frames in a row", errs);

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
common/blob_pkg.sv
hdl/frame_sync_ctrl.sv
blob/gray_convert.sv
blob/blob_tracker.sv
blob/blob_report.sv
hdl/blob_top.sv
verif/tb_clk_gen.sv
verif/blob_chk.sv
verif/blob_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= blob_tb
RTL_TOP   ?= blob_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

PASS_MSG := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
